/* tests/aln_cases.txt */
# T name | F data val pc fault type ecc | E pc instr icaf type dbecc second
# X flush | A async error | S stall cycles ; all numbers hex, pc in halfwords
T seq_4b
F 00000013 3 0000100 0 0 0
F 00100093 3 0000102 0 0 0
F 00208113 3 0000104 0 0 0
E 0000100 00000013 0 0 0 0
E 0000102 00100093 0 0 0 0
E 0000104 00208113 0 0 0 0
T mixed_straddle
F 05134501 3 0000200 0 0 0
F 808200a0 3 0000202 0 0 0
E 0000200 00004501 0 0 0 0
E 0000201 00a00513 0 0 0 0
E 0000203 00008082 0 0 0 0
T fault_second
F 05134505 3 0000300 0 0 0
F 000100a0 3 0000302 1 2 0
E 0000300 00004505 0 0 0 0
E 0000301 00a00513 1 2 0 1
E 0000303 00000001 0 2 0 0
T ecc_second
F 05134505 3 0000380 0 0 0
F 000100a0 3 0000382 0 1 1
E 0000380 00004505 0 0 0 0
E 0000381 00a00513 0 1 1 1
E 0000383 00000001 0 1 0 0
T flush_mid
F 00000013 3 0000400 0 0 0
F 00100093 3 0000402 0 0 0
E 0000400 00000013 0 0 0 0
X
F 00300193 3 0000500 0 0 0
E 0000500 00300193 0 0 0 0
T error_stall
F 00400213 3 0000600 0 0 0
A
S 4
X
F 00500293 3 0000700 0 0 0
E 0000700 00500293 0 0 0 0

/* sources.f */
source/ifu_aln_pkg.sv
source/ifu_aln_if.sv
source/aln_fetch_queue.sv
source/aln_valid_track.sv
source/aln_instr_extract.sv
source/ifu_aln_ctl.sv
tests/ifu_aln_assertions.sv
tests/tb_ifu_aln_ctl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ifu_aln_ctl
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || { echo "no pass line in log"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_ifu_aln_ctl.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_ifu_aln_ctl;

   localparam int WAIT_LIMIT = 32;   // cycles per wait loop

   logic                            clk;
   logic                            rst_n;
   logic                            async_error_start;
   logic                            flush;
   logic                            decode;
   logic [ifu_aln_pkg::FETCH_W-1:0] fetch_data;
   ifu_aln_pkg::half_vld_t          fetch_val;
   ifu_aln_pkg::pc_t                fetch_pc;
   logic [1:0]                      access_fault;
   ifu_aln_pkg::ictype_t            access_fault_type;
   logic [1:0]                      ecc_double_err;
   logic                            i0_valid;
   logic [ifu_aln_pkg::FETCH_W-1:0] i0_instr;
   ifu_aln_pkg::pc_t                i0_pc;
   logic                            i0_pc4;
   logic [ifu_aln_pkg::HALF_W-1:0]  i0_cinst;
   logic                            i0_icaf;
   ifu_aln_pkg::ictype_t            i0_icaf_type;
   logic                            i0_icaf_second;
   logic                            i0_dbecc;
   logic                            fb_consume1;
   logic                            fb_consume2;
   logic                            pmu_instr_aligned;

   int    value_errors;
   int    timeout_errors;
   int    n_fetch;
   int    n_discard;
   int    n_used;      // fetch words fully taken by the expected stream
   int    hw_taken;    // halfwords already taken from the oldest word
   int    n_c1;
   int    n_c2;
   string test_name;

   ifu_aln_pkg::pc_t fetch_pcs[$];   // words held by the aligner, oldest first

   ifu_aln_ctl u_ifu_aln_ctl (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // consume strobes sampled mid cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (fb_consume1) n_c1++;
         if (fb_consume2) n_c2++;
      end
   end

   function automatic int outstanding();
      return n_fetch - n_discard - n_c1 - 2 * n_c2;
   endfunction

   // **************************************************
   // compare tasks
   // **************************************************
   task automatic check_pc(input string what, input ifu_aln_pkg::pc_t exp,
                           input ifu_aln_pkg::pc_t act);
      if (exp !== act) begin
         $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_word(input string what, input ifu_aln_pkg::aligned_word_u exp,
                             input ifu_aln_pkg::aligned_word_u act);
      if (exp.word !== act.word) begin
         $display("Fail %s %s: expected %h actual %h", test_name, what, exp.word, act.word);
         value_errors++;
      end
   endtask

   task automatic check_half(input string what, input logic [ifu_aln_pkg::HALF_W-1:0] exp,
                             input logic [ifu_aln_pkg::HALF_W-1:0] act);
      if (exp !== act) begin
         $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_type(input string what, input ifu_aln_pkg::ictype_t exp,
                             input ifu_aln_pkg::ictype_t act);
      if (exp !== act) begin
         $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (exp !== act) begin
         $display("Fail %s %s: expected %b actual %b", test_name, what, exp, act);
         value_errors++;
      end
   endtask

   // **************************************************
   // stimulus steps
   // **************************************************
   task automatic do_fetch(input logic [31:0] data, input logic [31:0] val,
                           input logic [31:0] pc, input logic [31:0] fault,
                           input logic [31:0] typ, input logic [31:0] ecc);
      int i;
      i = 0;
      while (outstanding() >= ifu_aln_pkg::NUM_FB && i < WAIT_LIMIT) begin
         @(negedge clk);
         i++;
      end
      if (outstanding() >= ifu_aln_pkg::NUM_FB) begin
         $display("no fetch buffer became free in test %s", test_name);
         timeout_errors++;
      end else begin
         @(posedge clk);
         fetch_data        <= data;
         fetch_val         <= val[1:0];
         fetch_pc          <= pc[ifu_aln_pkg::PC_W-1:0];
         access_fault      <= fault[1:0];
         access_fault_type <= typ[ifu_aln_pkg::ICTYPE_W-1:0];
         ecc_double_err    <= ecc[1:0];
         @(posedge clk);
         fetch_val <= '0;
         n_fetch++;
         fetch_pcs.push_back(pc[ifu_aln_pkg::PC_W-1:0]);
      end
   endtask

   task automatic expect_instr(input logic [31:0] pc, input logic [31:0] instr,
                               input logic [31:0] icaf, input logic [31:0] typ,
                               input logic [31:0] dbecc, input logic [31:0] sec);
      int                         i;
      logic                       is4b;
      ifu_aln_pkg::aligned_word_u exp_w;
      ifu_aln_pkg::aligned_word_u act_w;
      is4b = (instr[1:0] == 2'b11);
      exp_w.word = is4b ? instr : {16'h0000, instr[15:0]};   // 2B zero extended
      i = 0;
      @(negedge clk);
      while (!i0_valid && i < WAIT_LIMIT) begin
         @(negedge clk);
         i++;
      end
      if (!i0_valid) begin
         $display("i0_valid never rose in test %s, pc %h expected", test_name, pc);
         timeout_errors++;
      end else begin
         act_w.word = i0_instr;
         check_pc("pc", pc[ifu_aln_pkg::PC_W-1:0], i0_pc);
         check_word("instr", exp_w, act_w);
         check_flag("pc4", is4b, i0_pc4);
         if (!is4b) check_half("cinst", instr[15:0], i0_cinst);
         check_flag("icaf", icaf[0], i0_icaf);
         check_type("icaf_type", typ[ifu_aln_pkg::ICTYPE_W-1:0], i0_icaf_type);
         check_flag("dbecc", dbecc[0], i0_dbecc);
         if (is4b) check_flag("icaf_second", sec[0], i0_icaf_second);
         @(posedge clk);
         decode <= 1'b1;
         @(negedge clk);
         check_flag("pmu_instr_aligned", 1'b1, pmu_instr_aligned);
         @(posedge clk);
         decode <= 1'b0;
         // retire the halfwords this instruction used
         hw_taken += is4b ? 2 : 1;
         while (hw_taken >= 2 && fetch_pcs.size() > 0) begin
            fetch_pcs.delete(0);
            hw_taken -= 2;
            n_used++;
         end
      end
   endtask

   task automatic flush_pipe();
      @(posedge clk);
      flush  <= 1'b1;
      decode <= 1'b0;
      @(posedge clk);
      flush <= 1'b0;
      n_discard += fetch_pcs.size();   // words still held are dropped
      fetch_pcs.delete();
      hw_taken = 0;
      @(negedge clk);
      check_flag("i0_valid after flush", 1'b0, i0_valid);
   endtask

   task automatic error_pulse();
      @(posedge clk);
      async_error_start <= 1'b1;
      @(posedge clk);
      async_error_start <= 1'b0;
   endtask

   task automatic stall_check(input int cycles);
      ifu_aln_pkg::pc_t exp_pc;
      logic             have_word;
      have_word = (fetch_pcs.size() > 0);
      exp_pc    = '0;
      if (have_word) exp_pc = fetch_pcs[0] + ifu_aln_pkg::pc_t'(hw_taken);
      for (int k = 0; k < cycles; k++) begin
         @(posedge clk);
         decode <= 1'b1;
         @(negedge clk);
         check_flag("pmu during stall", 1'b0, pmu_instr_aligned);
         if (have_word) check_pc("pc during stall", exp_pc, i0_pc);
      end
      @(posedge clk);
      decode <= 1'b0;
   endtask

   // **************************************************
   // main sequence
   // **************************************************
   initial begin
      int          fd;
      string       line;
      string       cmd;
      logic [31:0] a, b, c, d, e, f;
      rst_n             = 1'b0;
      async_error_start = 1'b0;
      flush             = 1'b0;
      decode            = 1'b0;
      fetch_data        = '0;
      fetch_val         = '0;
      fetch_pc          = '0;
      access_fault      = '0;
      access_fault_type = '0;
      ecc_double_err    = '0;
      value_errors      = 0;
      timeout_errors    = 0;
      n_fetch           = 0;
      n_discard         = 0;
      n_used            = 0;
      hw_taken          = 0;
      n_c1              = 0;
      n_c2              = 0;
      test_name         = "reset";
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      fd = $fopen("tests/aln_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open tests/aln_cases.txt");
         timeout_errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() < 1 || line[0] == "#" || line[0] == "\n") continue;
            void'($sscanf(line, "%s", cmd));
            case (cmd)
               "T": void'($sscanf(line, "%s %s", cmd, test_name));
               "F": begin
                  void'($sscanf(line, "%s %h %h %h %h %h %h", cmd, a, b, c, d, e, f));
                  do_fetch(a, b, c, d, e, f);
               end
               "E": begin
                  void'($sscanf(line, "%s %h %h %h %h %h %h", cmd, a, b, c, d, e, f));
                  expect_instr(a, b, c, d, e, f);
               end
               "X": flush_pipe();
               "A": error_pulse();
               "S": begin
                  void'($sscanf(line, "%s %d", cmd, a));
                  stall_check(int'(a));
               end
               default: begin
                  $display("unknown command in case file: %s", line);
                  timeout_errors++;
               end
            endcase
         end
         $fclose(fd);
      end

      // every fully used fetch must come back as consumes
      test_name = "accounting";
      repeat (2) @(negedge clk);
      if (n_c1 + 2 * n_c2 != n_used) begin
         $display("Fail %s consumed: expected %0d actual %0d", test_name,
                  n_used, n_c1 + 2 * n_c2);
         value_errors++;
      end

      $display("value errors %0d, timeout errors %0d", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/ifu_aln_assertions.sv */
`default_nettype none
`timescale 1ns/10ps

module ifu_aln_assertions (
   input wire logic                   clk,
   input wire logic                   rst_n,
   input wire logic                   flush,
   input wire ifu_aln_pkg::half_vld_t fetch_val,
   input wire logic                   fb_consume1,
   input wire logic                   fb_consume2,
   input wire logic                   i0_valid,
   input wire logic                   pmu_instr_aligned
);

   int fb_count;   // buffers held by the aligner

   always_ff @(posedge clk) begin
      if (!rst_n || flush) fb_count <= 0;
      else fb_count <= fb_count + int'(fetch_val[0]) - int'(fb_consume1)
                       - 2 * int'(fb_consume2);
   end

   // a buffer only drains when an instruction leaves
   consume_on_align: assert property (@(posedge clk) disable iff (!rst_n)
      (fb_consume1 || fb_consume2) |-> pmu_instr_aligned)
      else $error("fetch buffer consumed without an aligned instruction");

   quiet_in_reset: assert property (@(posedge clk)
      (!rst_n && $past(!rst_n)) |-> (!fb_consume1 && !fb_consume2 && !i0_valid))
      else $error("activity during reset");

   aligned_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
      pmu_instr_aligned |-> i0_valid)
      else $error("instruction aligned without i0_valid");

   fb_limit: assert property (@(posedge clk) disable iff (!rst_n)
      fb_count <= ifu_aln_pkg::NUM_FB)
      else $error("more than three fetch buffers outstanding");

endmodule

bind ifu_aln_ctl ifu_aln_assertions u_aln_assertions (
   .clk               (clk),
   .rst_n             (rst_n),
   .flush             (flush),
   .fetch_val         (fetch_val),
   .fb_consume1       (fb_consume1),
   .fb_consume2       (fb_consume2),
   .i0_valid          (i0_valid),
   .pmu_instr_aligned (pmu_instr_aligned)
);

`default_nettype wire

/* source/ifu_aln_ctl.sv */
`default_nettype none
`timescale 1ns/10ps

module ifu_aln_ctl (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            async_error_start,
   input  logic                            flush,
   input  logic                            decode,
   input  logic [ifu_aln_pkg::FETCH_W-1:0] fetch_data,
   input  ifu_aln_pkg::half_vld_t          fetch_val,
   input  ifu_aln_pkg::pc_t                fetch_pc,
   input  logic [1:0]                      access_fault,
   input  ifu_aln_pkg::ictype_t            access_fault_type,
   input  logic [1:0]                      ecc_double_err,
   output logic                            i0_valid,
   output logic [ifu_aln_pkg::FETCH_W-1:0] i0_instr,
   output ifu_aln_pkg::pc_t                i0_pc,
   output logic                            i0_pc4,
   output logic [ifu_aln_pkg::HALF_W-1:0]  i0_cinst,
   output logic                            i0_icaf,
   output ifu_aln_pkg::ictype_t            i0_icaf_type,
   output logic                            i0_icaf_second,
   output logic                            i0_dbecc,
   output logic                            fb_consume1,
   output logic                            fb_consume2,
   output logic                            pmu_instr_aligned
);

   fbq_rd_if    u_rd_if ();
   aln_ctl_if   u_ctl_if ();
   aln_shift_if u_sh_if ();

   aln_fetch_queue u_fetch_queue (
      .clk, .rst_n, .flush, .fetch_data, .fetch_val, .fetch_pc,
      .access_fault, .access_fault_type, .ecc_double_err,
      .ctl (u_ctl_if),
      .rd  (u_rd_if)
   );

   aln_valid_track u_valid_track (
      .clk, .rst_n, .flush, .fetch_val,
      .sh  (u_sh_if),
      .ctl (u_ctl_if)
   );

   aln_instr_extract u_instr_extract (
      .clk, .rst_n, .flush, .async_error_start, .decode,
      .rd  (u_rd_if),
      .sh  (u_sh_if),
      .i0_valid, .i0_instr, .i0_pc, .i0_pc4, .i0_cinst, .i0_icaf,
      .i0_icaf_type, .i0_icaf_second, .i0_dbecc, .pmu_instr_aligned
   );

   // buffer balance back to fetch
   assign fb_consume1 = u_ctl_if.consume1;
   assign fb_consume2 = u_ctl_if.consume2;

endmodule

`default_nettype wire

/* source/aln_instr_extract.sv */
`default_nettype none
`timescale 1ns/10ps

module aln_instr_extract (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            flush,
   input  logic                            async_error_start,
   input  logic                            decode,
   fbq_rd_if.extract                       rd,
   aln_shift_if.extract                    sh,
   output logic                            i0_valid,
   output logic [ifu_aln_pkg::FETCH_W-1:0] i0_instr,
   output ifu_aln_pkg::pc_t                i0_pc,
   output logic                            i0_pc4,
   output logic [ifu_aln_pkg::HALF_W-1:0]  i0_cinst,
   output logic                            i0_icaf,
   output ifu_aln_pkg::ictype_t            i0_icaf_type,
   output logic                            i0_icaf_second,
   output logic                            i0_dbecc,
   output logic                            pmu_instr_aligned
);

   ifu_aln_pkg::aligned_word_u aw;
   logic [1:0]                 alignval, alignicaf, aligndbecc;
   logic                       straddle, f1_contig, first4b;
   logic                       error_stall, i0_shift;

   // **************************************************
   // alignment
   // **************************************************
   assign straddle  = ~sh.f0val[1] & sh.f0val[0];   // only one half left in f0
   assign f1_contig = (rd.f1_pc == rd.f0_pc + ifu_aln_pkg::pc_t'(1));

   always_comb begin
      aw = rd.f0_word;
      if (!sh.f0val[1]) begin
         aw.half.hi = rd.f1_lo;          // upper half from next buffer
      end
   end

   assign alignval   = sh.f0val[1] ? 2'b11 : {straddle & sh.f1val[0] & f1_contig, sh.f0val[0]};
   assign alignicaf  = sh.f0val[1] ? rd.f0_icaf : {straddle & rd.f1_icaf, rd.f0_icaf[0]};
   assign aligndbecc = sh.f0val[1] ? rd.f0_dbecc : {straddle & rd.f1_dbecc, rd.f0_dbecc[0]};

   assign first4b = (aw.half.lo[1:0] == 2'b11);

   // **************************************************
   // instruction 0
   // **************************************************
   assign i0_valid = first4b ? alignval[1] : alignval[0];
   assign i0_instr = (first4b & alignval[1])  ? aw.word :
                     (~first4b & alignval[0]) ? {{ifu_aln_pkg::HALF_W{1'b0}}, aw.half.lo} : '0;
   assign i0_pc    = rd.f0_pc;
   assign i0_pc4   = first4b;
   assign i0_cinst = aw.half.lo;

   // fault anywhere in the instruction counts
   assign i0_icaf  = first4b ? |alignicaf : alignicaf[0];
   assign i0_dbecc = first4b ? |aligndbecc : aligndbecc[0];
   assign i0_icaf_second = alignicaf[1] | aligndbecc[1];

   // type follows the second fetch when the first half is clean
   assign i0_icaf_type = (first4b & straddle & ~alignicaf[0] & ~aligndbecc[0]) ?
                         rd.f1_ictype : rd.f0_ictype;

   // held until the pipe is flushed
   always_ff @(posedge clk) begin
      if (!rst_n) error_stall <= 1'b0;
      else error_stall <= (error_stall | async_error_start) & ~flush;
   end

   assign i0_shift          = decode & ~error_stall;
   assign pmu_instr_aligned = i0_shift;
   assign sh.shift_2b       = i0_shift & ~first4b;
   assign sh.shift_4b       = i0_shift & first4b;

endmodule

`default_nettype wire

/* source/aln_valid_track.sv */
`default_nettype none
`timescale 1ns/10ps

module aln_valid_track (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   flush,
   input  ifu_aln_pkg::half_vld_t fetch_val,
   aln_shift_if.track             sh,
   aln_ctl_if.track               ctl
);

   ifu_aln_pkg::half_vld_t f0val, f1val, f2val;
   ifu_aln_pkg::half_vld_t sf0val, sf1val;    // after this cycle's shift
   logic                   f0_shift_2b, f1_shift_2b;
   logic                   shift_f1_f0, shift_f2_f0, shift_f2_f1;
   logic                   fetch_to_f0, fetch_to_f1, fetch_to_f2;
   logic                   consume_fb0, consume_fb1;

   // queue offset moves
   assign f0_shift_2b = sh.f0val[0] & (sh.shift_2b | (sh.shift_4b & ~f0val[1]));
   assign f1_shift_2b = f0val[0] & ~f0val[1] & sh.shift_4b;   // straddle eats f1 low half

   assign sf0val = sh.shift_4b ? 2'b00 : sh.shift_2b ? {1'b0, f0val[1]} : f0val;
   assign sf1val = f1_shift_2b ? {1'b0, f1val[1]} : f1val;

   // **************************************************
   // moves by {sf0, sf1, f2} valid
   //   000 fetch to f0
   //   100 fetch to f1
   //   010 f1 to f0, fetch to f1
   //   001 f2 to f0, fetch to f1
   //   110 fetch to f2
   //   011 f1 to f0, f2 to f1, fetch to f2
   //   111 hold, no room
   // **************************************************
   assign shift_f1_f0 = ~sf0val[0] & sf1val[0];
   assign shift_f2_f0 = ~sf0val[0] & ~sf1val[0] & f2val[0];
   assign shift_f2_f1 = ~sf0val[0] & sf1val[0] & f2val[0];

   assign fetch_to_f0 = fetch_val[0] & ~sf0val[0] & ~sf1val[0] & ~f2val[0];
   assign fetch_to_f1 = fetch_val[0] & ((~sf0val[0] & (sf1val[0] ^ f2val[0])) |
                                        (sf0val[0] & ~sf1val[0] & ~f2val[0]));
   assign fetch_to_f2 = fetch_val[0] & sf1val[0] & (sf0val[0] ^ f2val[0]);

   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         f0val <= '0;
         f1val <= '0;
         f2val <= '0;
      end else begin
         if (fetch_to_f0) f0val <= fetch_val;
         else if (shift_f2_f0) f0val <= f2val;
         else if (shift_f1_f0) f0val <= sf1val;
         else f0val <= sf0val;

         if (fetch_to_f1) f1val <= fetch_val;
         else if (shift_f2_f1) f1val <= f2val;
         else if (shift_f1_f0) f1val <= '0;
         else f1val <= sf1val;

         if (fetch_to_f2) f2val <= fetch_val;
         else if (shift_f2_f1 || shift_f2_f0) f2val <= '0;
      end
   end

   // buffer fully drained this cycle
   assign consume_fb0 = f0val[0] & ~sf0val[0];
   assign consume_fb1 = f1val[0] & ~sf1val[0];

   assign ctl.consume1    = consume_fb0 & ~consume_fb1 & ~flush;
   assign ctl.consume2    = consume_fb0 & consume_fb1 & ~flush;
   assign ctl.f0_shift_2b = f0_shift_2b & ~flush;
   assign ctl.f1_shift_2b = f1_shift_2b & ~flush;

   assign sh.f0val = f0val;
   assign sh.f1val = f1val;

endmodule

`default_nettype wire

/* source/aln_fetch_queue.sv */
`default_nettype none
`timescale 1ns/10ps

module aln_fetch_queue (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            flush,
   input  logic [ifu_aln_pkg::FETCH_W-1:0] fetch_data,
   input  ifu_aln_pkg::half_vld_t          fetch_val,
   input  ifu_aln_pkg::pc_t                fetch_pc,
   input  logic [1:0]                      access_fault,
   input  ifu_aln_pkg::ictype_t            access_fault_type,
   input  logic [1:0]                      ecc_double_err,
   aln_ctl_if.queue                        ctl,
   fbq_rd_if.queue                         rd
);

   logic [ifu_aln_pkg::FETCH_W-1:0] q_data   [ifu_aln_pkg::NUM_FB];
   ifu_aln_pkg::pc_t                q_pc     [ifu_aln_pkg::NUM_FB];
   logic [1:0]                      q_icaf   [ifu_aln_pkg::NUM_FB];
   logic [1:0]                      q_dbecc  [ifu_aln_pkg::NUM_FB];
   ifu_aln_pkg::ictype_t            q_ictype [ifu_aln_pkg::NUM_FB];
   logic [ifu_aln_pkg::NUM_FB-1:0]  q_off;      // low half already taken
   logic [ifu_aln_pkg::NUM_FB-1:0]  qwen;
   logic [ifu_aln_pkg::PTR_W-1:0]   wrptr, rdptr, rd1ptr;
   logic                            f0_off, f1_off;

   function automatic logic [ifu_aln_pkg::PTR_W-1:0] ptr_inc(
      input logic [ifu_aln_pkg::PTR_W-1:0] p);
      return (p == ifu_aln_pkg::PTR_LAST) ? '0 : p + 1'b1;
   endfunction

   assign rd1ptr = ptr_inc(rdptr);       // entry behind f0

   always_comb begin
      for (int i = 0; i < ifu_aln_pkg::NUM_FB; i++) begin
         qwen[i] = fetch_val[0] & (wrptr == i[ifu_aln_pkg::PTR_W-1:0]);
      end
   end

   // **************************************************
   // pointers and offsets
   // **************************************************
   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         wrptr <= '0;
         rdptr <= '0;
      end else begin
         if (fetch_val[0]) wrptr <= ptr_inc(wrptr);
         if (ctl.consume2) rdptr <= ptr_inc(rd1ptr);
         else if (ctl.consume1) rdptr <= rd1ptr;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         q_off <= '0;
      end else begin
         for (int i = 0; i < ifu_aln_pkg::NUM_FB; i++) begin
            if (qwen[i]) q_off[i] <= 1'b0;       // fresh word
            else if (rdptr == i[ifu_aln_pkg::PTR_W-1:0]) q_off[i] <= q_off[i] | ctl.f0_shift_2b;
            else if (rd1ptr == i[ifu_aln_pkg::PTR_W-1:0]) q_off[i] <= q_off[i] | ctl.f1_shift_2b;
         end
      end
   end

   // entry payload
   always_ff @(posedge clk) begin
      for (int i = 0; i < ifu_aln_pkg::NUM_FB; i++) begin
         if (qwen[i]) begin
            q_data[i]   <= fetch_data;
            q_pc[i]     <= fetch_pc;
            q_icaf[i]   <= access_fault;
            q_dbecc[i]  <= ecc_double_err;
            q_ictype[i] <= access_fault_type;
         end
      end
   end

   // **************************************************
   // read side
   // **************************************************
   assign f0_off = q_off[rdptr];
   assign f1_off = q_off[rd1ptr];

   // f0 drops its low half once consumed
   assign rd.f0_word   = f0_off ? {{ifu_aln_pkg::HALF_W{1'b0}},
                                   q_data[rdptr][ifu_aln_pkg::FETCH_W-1:ifu_aln_pkg::HALF_W]}
                                : q_data[rdptr];
   assign rd.f0_pc     = q_pc[rdptr] + ifu_aln_pkg::pc_t'(f0_off);
   assign rd.f0_icaf   = f0_off ? {1'b0, q_icaf[rdptr][1]} : q_icaf[rdptr];
   assign rd.f0_dbecc  = f0_off ? {1'b0, q_dbecc[rdptr][1]} : q_dbecc[rdptr];
   assign rd.f0_ictype = q_ictype[rdptr];

   assign rd.f1_lo     = f1_off ? q_data[rd1ptr][ifu_aln_pkg::FETCH_W-1:ifu_aln_pkg::HALF_W]
                                : q_data[rd1ptr][ifu_aln_pkg::HALF_W-1:0];
   assign rd.f1_pc     = q_pc[rd1ptr] + ifu_aln_pkg::pc_t'(f1_off);
   assign rd.f1_icaf   = q_icaf[rd1ptr][f1_off];
   assign rd.f1_dbecc  = q_dbecc[rd1ptr][f1_off];
   assign rd.f1_ictype = q_ictype[rd1ptr];

endmodule

`default_nettype wire

/* source/ifu_aln_if.sv */
`default_nettype none
`timescale 1ns/10ps

// queue read side, two oldest entries
interface fbq_rd_if;
   ifu_aln_pkg::aligned_word_u     f0_word;     // offset already applied
   ifu_aln_pkg::pc_t               f0_pc;
   logic [1:0]                     f0_icaf;
   logic [1:0]                     f0_dbecc;
   ifu_aln_pkg::ictype_t           f0_ictype;
   logic [ifu_aln_pkg::HALF_W-1:0] f1_lo;
   ifu_aln_pkg::pc_t               f1_pc;
   logic                           f1_icaf;     // low half only
   logic                           f1_dbecc;
   ifu_aln_pkg::ictype_t           f1_ictype;

   modport queue (output f0_word, f0_pc, f0_icaf, f0_dbecc, f0_ictype,
                  output f1_lo, f1_pc, f1_icaf, f1_dbecc, f1_ictype);
   modport extract (input f0_word, f0_pc, f0_icaf, f0_dbecc, f0_ictype,
                    input f1_lo, f1_pc, f1_icaf, f1_dbecc, f1_ictype);
endinterface

// tracker to queue, pointer and offset moves
interface aln_ctl_if;
   logic consume1;
   logic consume2;
   logic f0_shift_2b;
   logic f1_shift_2b;

   modport track (output consume1, consume2, f0_shift_2b, f1_shift_2b);
   modport queue (input consume1, consume2, f0_shift_2b, f1_shift_2b);
endinterface

// valid state out, shift request back
interface aln_shift_if;
   ifu_aln_pkg::half_vld_t f0val;
   ifu_aln_pkg::half_vld_t f1val;
   logic                   shift_2b;
   logic                   shift_4b;

   modport extract (input f0val, f1val, output shift_2b, shift_4b);
   modport track (output f0val, f1val, input shift_2b, shift_4b);
endinterface

`default_nettype wire

/* source/ifu_aln_pkg.sv */
`default_nettype none

package ifu_aln_pkg;

   // **************************************************
   // widths
   // **************************************************
   localparam int FETCH_W  = 32;     // one fetch word
   localparam int HALF_W   = 16;
   localparam int PC_W     = 31;     // pc[31:1]
   localparam int ICTYPE_W = 2;

   // **************************************************
   // fetch buffer ring
   // **************************************************
   localparam int NUM_FB = 3;
   localparam int PTR_W  = 2;
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(NUM_FB - 1);   // wrap point

   typedef logic [PC_W-1:0]     pc_t;
   typedef logic [1:0]          half_vld_t;     // right justified, bit 0 = low half
   typedef logic [ICTYPE_W-1:0] ictype_t;

   typedef struct packed {
      logic [HALF_W-1:0] hi;
      logic [HALF_W-1:0] lo;
   } half_pair_t;

   // aligned word, 4B view or halfword view
   typedef union packed {
      logic [FETCH_W-1:0] word;
      half_pair_t         half;
   } aligned_word_u;

endpackage

`default_nettype wire
